// File: src.f
camera_pkg.sv
delay_line.sv
divider.sv
pixel_reconstruct.sv
chroma_mask.sv
center_of_mass.sv
video_mux.sv
tracker_top.sv
tb_tracker.sv

// File: Bender.yml
package:
  name: camera_tracker

sources:
  - camera_pkg.sv
  - delay_line.sv
  - divider.sv
  - pixel_reconstruct.sv
  - chroma_mask.sv
  - center_of_mass.sv
  - video_mux.sv
  - tracker_top.sv
  - target: test
    files:
      - tb_tracker.sv

// File: tb_tracker.sv
`timescale 1ns/1ps

module tb_tracker import camera_pkg::*; ();

   // camera bus timing in clk_camera cycles and pixel clocks
   localparam int PCLK_HALF  = 3;
   localparam int LINE_BLANK = 8;
   localparam int VS_BLANK   = 100;
   localparam int VS_PULSE   = 10;
   localparam int WAIT_LIMIT = 2000;
   // centre update lands within 30 cycles of the last pixel
   localparam int COM_LIMIT  = 64;
   localparam logic [PIXEL_W-1:0] PINK = 16'hF81F;

   logic                 clk_camera;
   logic                 sys_rst_camera;
   logic [7:0]           camera_d_i;
   logic                 cam_pclk_i;
   logic                 cam_hsync_i;
   logic                 cam_vsync_i;
   display_mode_t        display_mode_i;
   logic [FB_ADDR_W-1:0] fb_addr_o;
   logic [PIXEL_W-1:0]   fb_data_o;
   logic                 fb_we_o;
   logic [HCOUNT_W-1:0]  com_x_o;
   logic [VCOUNT_W-1:0]  com_y_o;
   logic                 com_valid_o;

   // words of the frame being sent, indexed by address
   logic [PIXEL_W-1:0] frame_words [FB_DEPTH];
   logic [31:0]        rng_state;
   display_mode_t      cur_mode;
   // held centre and the one the current frame should produce
   int                 exp_cx, exp_cy, next_cx, next_cy;
   logic               com_expect;
   int                 wr_idx, total_writes, com_pulses, exp_pulses;

   tracker_top DUT (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .camera_d_i     (camera_d_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .display_mode_i (display_mode_i),
      .fb_addr_o      (fb_addr_o),
      .fb_data_o      (fb_data_o),
      .fb_we_o        (fb_we_o),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o)
   );

   initial begin
      clk_camera = 1'b0;
      forever #2 clk_camera = ~clk_camera;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic int clamp_byte(input int v);
      if (v < 0) begin
         return 0;
      end else if (v > 255) begin
         return 255;
      end
      return v;
   endfunction

   // fields widened by zero padding, weights scaled by 256
   function automatic int weighted_sum(input logic [15:0] w, input int cr, input int cg,
                                       input int cb, input int off);
      int r, g, b;
      r = int'(w[15:11]) * 8;
      g = int'(w[10:5]) * 4;
      b = int'(w[4:0]) * 8;
      return clamp_byte(((r * cr + g * cg + b * cb) >>> 8) + off);
   endfunction

   function automatic int luma_of(input logic [15:0] w);
      return weighted_sum(w, Y_COEF_R, Y_COEF_G, Y_COEF_B, Y_OFFSET);
   endfunction

   function automatic bit in_pink_window(input logic [15:0] w);
      int c;
      c = weighted_sum(w, CR_COEF_R, CR_COEF_G, CR_COEF_B, CR_OFFSET);
      return (c >= int'(MASK_LOWER)) && (c <= int'(MASK_UPPER));
   endfunction

   // expected frame-buffer word for one pixel
   function automatic logic [15:0] expected_data(input logic [15:0] w, input int x, input int y,
                                                 input display_mode_t mode, input int cx,
                                                 input int cy);
      int l;
      l = luma_of(w);
      case (mode)
         MODE_LUMA: return {l[7:3], l[7:2], l[7:3]};
         MODE_MASK: return in_pink_window(w) ? 16'hFFFF : 16'h0000;
         MODE_CROSSHAIR: return (x == cx || y == cy) ? 16'hFFFF : w;
         default: return w;
      endcase
   endfunction

   task automatic tick(input int n);
      repeat (n) begin
         @(posedge clk_camera);
         #1;
      end
   endtask

   task automatic stop_with(input string msg);
      $display("%s (time %0t)", msg, $time);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
      $display("[FAIL] time %0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // random words, optional pink patch, dark frames keep red low
   task automatic build_frame(input bit patch, input bit dark);
      int sx, sy, cnt, x, y;
      sx  = 0;
      sy  = 0;
      cnt = 0;
      for (int a = 0; a < FB_DEPTH; a++) begin
         x = a % FRAME_W;
         y = a / FRAME_W;
         rng_state = xorshift32(rng_state);
         frame_words[a] = dark ? (rng_state[15:0] & 16'h39FF) : rng_state[15:0];
         if (patch && x >= 200 && x < 240 && y >= 40 && y < 80) begin
            frame_words[a] = PINK;
         end
         if (in_pink_window(frame_words[a])) begin
            sx  += x;
            sy  += y;
            cnt += 1;
         end
      end
      com_expect = (cnt != 0);
      if (cnt != 0) begin
         next_cx    = sx / cnt;
         next_cy    = sy / cnt;
         exp_pulses += 1;
      end
   endtask

   // one pixel clock period, data set while the clock is low
   task automatic pclk_period(input logic [7:0] d, input logic hs, input logic vs);
      camera_d_i  = d;
      cam_hsync_i = hs;
      cam_vsync_i = vs;
      cam_pclk_i  = 1'b0;
      tick(PCLK_HALF);
      cam_pclk_i = 1'b1;
      tick(PCLK_HALF);
   endtask

   task automatic send_frame(input display_mode_t mode);
      int a;
      display_mode_i = mode;
      cur_mode       = mode;
      wr_idx         = 0;
      repeat (VS_BLANK) pclk_period(8'h00, 1'b0, 1'b0);
      repeat (VS_PULSE) pclk_period(8'h00, 1'b0, 1'b1);
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            a = y * FRAME_W + x;
            // high byte first
            pclk_period(frame_words[a][15:8], 1'b1, 1'b0);
            pclk_period(frame_words[a][7:0], 1'b1, 1'b0);
         end
         repeat (LINE_BLANK) pclk_period(8'h00, 1'b0, 1'b0);
      end
   endtask

   task automatic run_frame(input display_mode_t mode, input bit patch, input bit dark);
      int t;
      build_frame(patch, dark);
      send_frame(mode);
      t = 0;
      while (wr_idx < FB_DEPTH && t < WAIT_LIMIT) begin
         tick(1);
         t++;
      end
      assert (wr_idx == FB_DEPTH)
         else stop_with("frame ended without all frame-buffer writes");
      t = 0;
      while (com_pulses < exp_pulses && t < COM_LIMIT) begin
         tick(1);
         t++;
      end
      assert (com_pulses == exp_pulses)
         else stop_with("com_valid_o never pulsed after a frame with pink pixels");
      // quiet gap, a late or stray update shows up here
      tick(COM_LIMIT);
      assert (com_x_o == HCOUNT_W'(exp_cx)) else value_mismatch("com_x_o", com_x_o, exp_cx);
      assert (com_y_o == VCOUNT_W'(exp_cy)) else value_mismatch("com_y_o", com_y_o, exp_cy);
   endtask

   // checker, outputs are settled at the falling edge
   always @(negedge clk_camera) begin : monitor
      logic [15:0] exp_word;
      if (!sys_rst_camera && fb_we_o) begin
         assert (wr_idx < FB_DEPTH) else stop_with("write strobe seen outside of a frame");
         assert (fb_addr_o == FB_ADDR_W'(wr_idx))
            else value_mismatch("fb_addr_o", fb_addr_o, wr_idx);
         exp_word = expected_data(frame_words[wr_idx], wr_idx % FRAME_W, wr_idx / FRAME_W,
                                  cur_mode, exp_cx, exp_cy);
         assert (fb_data_o == exp_word) else value_mismatch("fb_data_o", fb_data_o, exp_word);
         wr_idx       += 1;
         total_writes += 1;
      end
      if (!sys_rst_camera && com_valid_o) begin
         assert (com_expect) else stop_with("com_valid_o pulsed with no pink pixels to track");
         assert (com_x_o == HCOUNT_W'(next_cx)) else value_mismatch("com_x_o", com_x_o, next_cx);
         assert (com_y_o == VCOUNT_W'(next_cy)) else value_mismatch("com_y_o", com_y_o, next_cy);
         exp_cx     = next_cx;
         exp_cy     = next_cy;
         com_expect = 1'b0;
         com_pulses += 1;
      end
   end

   initial begin : stimulus
      sys_rst_camera = 1'b1;
      camera_d_i     = 8'h00;
      cam_pclk_i     = 1'b0;
      cam_hsync_i    = 1'b0;
      cam_vsync_i    = 1'b0;
      display_mode_i = MODE_CAMERA;
      cur_mode       = MODE_CAMERA;
      rng_state      = 32'd14;
      exp_cx         = 0;
      exp_cy         = 0;
      next_cx        = 0;
      next_cy        = 0;
      com_expect     = 1'b0;
      wr_idx         = 0;
      total_writes   = 0;
      com_pulses     = 0;
      exp_pulses     = 0;
      repeat (5) @(posedge clk_camera);
      #1 sys_rst_camera = 1'b0;
      // quiet outputs before any camera traffic
      for (int i = 0; i < 20; i++) begin
         tick(1);
         assert (fb_we_o == 1'b0) else value_mismatch("fb_we_o", fb_we_o, 0);
         assert (com_valid_o == 1'b0) else value_mismatch("com_valid_o", com_valid_o, 0);
         assert (com_x_o == '0) else value_mismatch("com_x_o", com_x_o, 0);
         assert (com_y_o == '0) else value_mismatch("com_y_o", com_y_o, 0);
      end
      run_frame(MODE_CAMERA, 1'b1, 1'b0);
      run_frame(MODE_LUMA, 1'b1, 1'b0);
      run_frame(MODE_MASK, 1'b1, 1'b0);
      // crosshair on the held centre, frame itself has no pink
      run_frame(MODE_CROSSHAIR, 1'b0, 1'b1);
      if (total_writes == 4 * FB_DEPTH && com_pulses == exp_pulses) begin
         $display("Simulation passed");
         $finish;
      end else begin
         stop_with("write count or centre update count wrong at end of run");
      end
   end

endmodule

// File: tracker_top.sv
`timescale 1ns/1ps

module tracker_top import camera_pkg::*; (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   // camera bus
   input  logic [7:0]           camera_d_i,
   input  logic                 cam_pclk_i,
   input  logic                 cam_hsync_i,
   input  logic                 cam_vsync_i,
   input  display_mode_t        display_mode_i,
   // frame-buffer write port
   output logic [FB_ADDR_W-1:0] fb_addr_o,
   output logic [PIXEL_W-1:0]   fb_data_o,
   output logic                 fb_we_o,
   // held centre of mass
   output logic [HCOUNT_W-1:0]  com_x_o,
   output logic [VCOUNT_W-1:0]  com_y_o,
   output logic                 com_valid_o
);

   // straight from capture
   logic               pix_valid;
   logic [PIXEL_W-1:0] pix_data;
   px_coord_t          pix_coord;
   // aligned with the chroma output
   logic               al_valid;
   logic [CHAN_W-1:0]  al_luma;
   logic               al_mask;
   px_coord_t          al_coord;
   logic [PIXEL_W-1:0] al_pixel;

   pixel_reconstruct u_capture (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .camera_d_i     (camera_d_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pix_valid_o    (pix_valid),
      .pix_data_o     (pix_data),
      .pix_coord_o    (pix_coord)
   );

   chroma_mask u_chroma (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .valid_i        (pix_valid),
      .pixel_i        (pix_data),
      .valid_o        (al_valid),
      .luma_o         (al_luma),
      .mask_o         (al_mask)
   );

   // coordinate and pixel follow the chroma pipeline
   delay_line #(.T(px_coord_t), .DEPTH(CHROMA_LATENCY)) u_coord_dly (
      .clk_camera (clk_camera),
      .data_i     (pix_coord),
      .data_o     (al_coord)
   );

   delay_line #(.T(logic [PIXEL_W-1:0]), .DEPTH(CHROMA_LATENCY)) u_pixel_dly (
      .clk_camera (clk_camera),
      .data_i     (pix_data),
      .data_o     (al_pixel)
   );

   center_of_mass u_com (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .valid_i        (al_valid),
      .coord_i        (al_coord),
      .mask_i         (al_mask),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o)
   );

   video_mux u_mux (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .valid_i        (al_valid),
      .coord_i        (al_coord),
      .pixel_i        (al_pixel),
      .luma_i         (al_luma),
      .mask_i         (al_mask),
      .com_x_i        (com_x_o),
      .com_y_i        (com_y_o),
      .display_mode_i (display_mode_i),
      .fb_addr_o      (fb_addr_o),
      .fb_data_o      (fb_data_o),
      .fb_we_o        (fb_we_o)
   );

endmodule

// File: video_mux.sv
`timescale 1ns/1ps

module video_mux import camera_pkg::*; (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  logic                 valid_i,
   input  px_coord_t            coord_i,
   input  logic [PIXEL_W-1:0]   pixel_i,
   input  logic [CHAN_W-1:0]    luma_i,
   input  logic                 mask_i,
   input  logic [HCOUNT_W-1:0]  com_x_i,
   input  logic [VCOUNT_W-1:0]  com_y_i,
   input  display_mode_t        display_mode_i,
   output logic [FB_ADDR_W-1:0] fb_addr_o,
   output logic [PIXEL_W-1:0]   fb_data_o,
   output logic                 fb_we_o
);

   logic [FB_ADDR_W-1:0] addr_calc;
   logic [PIXEL_W-1:0]   mode_data;
   logic                 on_cross;

   always_comb begin
      // row-major frame-buffer layout
      addr_calc = FB_ADDR_W'(coord_i.y) * FB_ADDR_W'(FRAME_W) + FB_ADDR_W'(coord_i.x);
      on_cross  = (coord_i.x == com_x_i) || (coord_i.y == com_y_i);
      case (display_mode_i)
         MODE_CAMERA: begin
            mode_data = pixel_i;
         end
         MODE_LUMA: begin
            // grey, same luma in every field
            mode_data = {luma_i[7:3], luma_i[7:2], luma_i[7:3]};
         end
         MODE_MASK: begin
            mode_data = mask_i ? '1 : '0;
         end
         MODE_CROSSHAIR: begin
            mode_data = on_cross ? '1 : pixel_i;
         end
         default: begin
            mode_data = pixel_i;
         end
      endcase
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         fb_we_o <= 1'b0;
      end else begin
         fb_we_o <= valid_i;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (valid_i) begin
         fb_addr_o <= addr_calc;
         fb_data_o <= mode_data;
      end
   end

endmodule

// File: center_of_mass.sv
`timescale 1ns/1ps

module center_of_mass import camera_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                valid_i,
   input  px_coord_t           coord_i,
   input  logic                mask_i,
   output logic [HCOUNT_W-1:0] com_x_o,
   output logic [VCOUNT_W-1:0] com_y_o,
   output logic                com_valid_o
);

   // running sums for the current frame
   logic [SUM_W-1:0] sum_x, sum_y;
   logic [SUM_W-1:0] next_sum_x, next_sum_y;
   logic [CNT_W-1:0] cnt, next_cnt;
   logic             hit;
   logic             last_px;
   // captured operands for the dividers
   logic             start_div;
   logic [SUM_W-1:0] div_in_x, div_in_y;
   logic [CNT_W-1:0] div_in_cnt;
   // divider results
   logic             done_x, done_y;
   logic             both_done;
   logic [SUM_W-1:0] quo_x, quo_y;

   always_comb begin
      hit     = valid_i && mask_i;
      last_px = valid_i && (coord_i.x == HCOUNT_W'(FRAME_W - 1))
                        && (coord_i.y == VCOUNT_W'(FRAME_H - 1));
      // include the current pixel so the last one is counted too
      next_sum_x = sum_x + (hit ? SUM_W'(coord_i.x) : '0);
      next_sum_y = sum_y + (hit ? SUM_W'(coord_i.y) : '0);
      next_cnt   = cnt + CNT_W'(hit);
      // same start and fixed latency, both finish together
      both_done  = done_x && done_y;
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         sum_x       <= '0;
         sum_y       <= '0;
         cnt         <= '0;
         start_div   <= 1'b0;
         com_x_o     <= '0;
         com_y_o     <= '0;
         com_valid_o <= 1'b0;
      end else begin
         if (last_px) begin
            sum_x <= '0;
            sum_y <= '0;
            cnt   <= '0;
         end else begin
            sum_x <= next_sum_x;
            sum_y <= next_sum_y;
            cnt   <= next_cnt;
         end
         // empty frame leaves the held centre alone
         start_div <= last_px && (next_cnt != '0);
         com_valid_o <= both_done;
         if (both_done) begin
            com_x_o <= quo_x[HCOUNT_W-1:0];
            com_y_o <= quo_y[VCOUNT_W-1:0];
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (last_px) begin
         div_in_x   <= next_sum_x;
         div_in_y   <= next_sum_y;
         div_in_cnt <= next_cnt;
      end
   end

   divider u_div_x (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (start_div),
      .dividend_i     (div_in_x),
      .divisor_i      (div_in_cnt),
      .done_o         (done_x),
      .quotient_o     (quo_x)
   );

   divider u_div_y (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (start_div),
      .dividend_i     (div_in_y),
      .divisor_i      (div_in_cnt),
      .done_o         (done_y),
      .quotient_o     (quo_y)
   );

endmodule

// File: chroma_mask.sv
`timescale 1ns/1ps

module chroma_mask import camera_pkg::*; (
   input  logic               clk_camera,
   input  logic               sys_rst_camera,
   input  logic               valid_i,
   input  logic [PIXEL_W-1:0] pixel_i,
   output logic               valid_o,
   output logic [CHAN_W-1:0]  luma_o,
   output logic               mask_o
);

   // stage one, widened channels
   logic              v1;
   logic [CHAN_W-1:0] r8, g8, b8;
   // weighted sums before clamping
   logic signed [2*CHAN_W+3:0] y_acc, cr_acc;
   logic signed [2*CHAN_W+3:0] y_full, cr_full;
   // stage two, clamped results
   logic              v2;
   logic [CHAN_W-1:0] y_st2, cr_st2;

   function automatic logic [CHAN_W-1:0] clamp_chan(input logic signed [2*CHAN_W+3:0] v);
      if (v < 0) begin
         return '0;
      end else if (v > 255) begin
         return '1;
      end
      return v[CHAN_W-1:0];
   endfunction

   // valid chain
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         v1      <= 1'b0;
         v2      <= 1'b0;
         valid_o <= 1'b0;
      end else begin
         v1      <= valid_i;
         v2      <= v1;
         valid_o <= v2;
      end
   end

   always_comb begin
      // products are signed, channels treated as positive
      y_acc  = $signed({1'b0, r8}) * Y_COEF_R + $signed({1'b0, g8}) * Y_COEF_G
             + $signed({1'b0, b8}) * Y_COEF_B;
      cr_acc = $signed({1'b0, r8}) * CR_COEF_R + $signed({1'b0, g8}) * CR_COEF_G
             + $signed({1'b0, b8}) * CR_COEF_B;
      y_full  = (y_acc >>> 8) + Y_OFFSET;
      cr_full = (cr_acc >>> 8) + CR_OFFSET;
   end

   always_ff @(posedge clk_camera) begin
      // rgb565 fields padded with zeros
      r8 <= {pixel_i[15:11], 3'b000};
      g8 <= {pixel_i[10:5], 2'b00};
      b8 <= {pixel_i[4:0], 3'b000};
      y_st2  <= clamp_chan(y_full);
      cr_st2 <= clamp_chan(cr_full);
      luma_o <= y_st2;
      // inclusive window test
      mask_o <= (cr_st2 >= MASK_LOWER) && (cr_st2 <= MASK_UPPER);
   end

endmodule

// File: pixel_reconstruct.sv
`timescale 1ns/1ps

module pixel_reconstruct import camera_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic [7:0]          camera_d_i,
   input  logic                cam_pclk_i,
   input  logic                cam_hsync_i,
   input  logic                cam_vsync_i,
   output logic                pix_valid_o,
   output logic [PIXEL_W-1:0]  pix_data_o,
   output px_coord_t           pix_coord_o
);

   // two-flop synchronizers
   logic [7:0] d_s1, d_s2;
   logic       pclk_s1, pclk_s2;
   logic       hs_s1, hs_s2;
   logic       vs_s1, vs_s2;

   // edge detect stage, data kept aligned with the edge flag
   logic       pclk_prev;
   logic       pclk_rise;
   logic [7:0] d_r;
   logic       hs_r, hs_prev;
   logic       vs_r;

   // byte pairing and counters
   logic                low_phase;
   logic [7:0]          high_byte;
   logic [HCOUNT_W-1:0] hcount;
   logic [VCOUNT_W-1:0] vcount;
   logic                take_byte;
   logic                hs_fall;

   always_ff @(posedge clk_camera) begin
      d_s1    <= camera_d_i;
      d_s2    <= d_s1;
      pclk_s1 <= cam_pclk_i;
      pclk_s2 <= pclk_s1;
      hs_s1   <= cam_hsync_i;
      hs_s2   <= hs_s1;
      vs_s1   <= cam_vsync_i;
      vs_s2   <= vs_s1;
      // one more stage so data lines up with pclk_rise
      pclk_prev <= pclk_s2;
      d_r       <= d_s2;
      hs_r      <= hs_s2;
      hs_prev   <= hs_r;
      vs_r      <= vs_s2;
   end

   // rising edge of the sampled pixel clock
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_rise <= 1'b0;
      end else begin
         pclk_rise <= pclk_s2 & ~pclk_prev;
      end
   end

   always_comb begin
      take_byte = pclk_rise && hs_r && !vs_r;
      hs_fall   = hs_prev && !hs_r && !vs_r;
   end

   // control: phase, counters, valid strobe
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         low_phase   <= 1'b0;
         hcount      <= '0;
         vcount      <= '0;
         pix_valid_o <= 1'b0;
      end else begin
         pix_valid_o <= 1'b0;
         if (vs_r) begin
            // frame start, back to column 0 row 0
            low_phase <= 1'b0;
            hcount    <= '0;
            vcount    <= '0;
         end else if (hs_fall) begin
            low_phase <= 1'b0;
            hcount    <= '0;
            vcount    <= vcount + 1'b1;
         end else if (take_byte) begin
            low_phase <= ~low_phase;
            if (low_phase) begin
               pix_valid_o <= 1'b1;
               hcount      <= hcount + 1'b1;
            end
         end
      end
   end

   // payload: high byte first, low byte completes the word
   always_ff @(posedge clk_camera) begin
      if (take_byte && !low_phase) begin
         high_byte <= d_r;
      end
      if (take_byte && low_phase) begin
         pix_data_o    <= {high_byte, d_r};
         pix_coord_o.x <= hcount;
         pix_coord_o.y <= vcount;
      end
   end

endmodule

// File: divider.sv
`timescale 1ns/1ps

module divider import camera_pkg::*; (
   input  logic             clk_camera,
   input  logic             sys_rst_camera,
   input  logic             start_i,
   input  logic [SUM_W-1:0] dividend_i,
   input  logic [CNT_W-1:0] divisor_i,
   output logic             done_o,
   output logic [SUM_W-1:0] quotient_o
);

   logic                  busy;
   logic [DIV_STEP_W-1:0] bits_left;
   // dividend shifts out the top while quotient bits enter at the bottom
   logic [SUM_W-1:0]      quo;
   logic [CNT_W-1:0]      rem;
   logic [CNT_W-1:0]      div;
   logic [CNT_W:0]        shifted;
   logic [CNT_W:0]        diff;
   logic                  fits;

   always_comb begin
      shifted = {rem, quo[SUM_W-1]};
      diff    = shifted - {1'b0, div};
      fits    = shifted >= {1'b0, div};
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy      <= 1'b0;
         bits_left <= '0;
         done_o    <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i && !busy) begin
            busy      <= 1'b1;
            bits_left <= DIV_STEP_W'(SUM_W);
         end else if (busy) begin
            if (bits_left == '0) begin
               // all bits resolved, one cycle to publish
               busy   <= 1'b0;
               done_o <= 1'b1;
            end else begin
               bits_left <= bits_left - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (start_i && !busy) begin
         quo <= dividend_i;
         rem <= '0;
         div <= divisor_i;
      end else if (busy && bits_left != '0) begin
         // restore by keeping the old remainder when the trial fails
         rem <= fits ? diff[CNT_W-1:0] : shifted[CNT_W-1:0];
         quo <= {quo[SUM_W-2:0], fits};
      end
      if (busy && bits_left == '0) begin
         quotient_o <= quo;
      end
   end

endmodule

// File: delay_line.sv
`timescale 1ns/1ps

module delay_line #(
   parameter type T     = logic,
   parameter int  DEPTH = 1
) (
   input  logic clk_camera,
   input  T     data_i,
   output T     data_o
);

   // shift register, one slot per cycle of delay
   T pipe [DEPTH];

   always_ff @(posedge clk_camera) begin
      pipe[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
         pipe[i] <= pipe[i-1];
      end
   end

   assign data_o = pipe[DEPTH-1];

endmodule

// File: camera_pkg.sv
package camera_pkg;

   // frame geometry
   localparam int FRAME_W = 320;
   localparam int FRAME_H = 180;
   localparam int FB_DEPTH = FRAME_W * FRAME_H;
   localparam int FB_ADDR_W = $clog2(FB_DEPTH);

   // counter and data widths
   localparam int HCOUNT_W = 9;
   localparam int VCOUNT_W = 8;
   localparam int PIXEL_W = 16;
   localparam int CHAN_W = 8;

   // per-frame sums, worst case 319 * 57600 still fits
   localparam int SUM_W = 25;
   localparam int CNT_W = 16;
   // divider step counter
   localparam int DIV_STEP_W = $clog2(SUM_W + 1);

   // luma weights, scaled by 256
   localparam logic signed [8:0] Y_COEF_R = 9'sd66;
   localparam logic signed [8:0] Y_COEF_G = 9'sd129;
   localparam logic signed [8:0] Y_COEF_B = 9'sd25;
   localparam logic signed [8:0] Y_OFFSET = 9'sd16;

   // red-difference chroma weights, scaled by 256
   localparam logic signed [8:0] CR_COEF_R = 9'sd112;
   localparam logic signed [8:0] CR_COEF_G = -9'sd94;
   localparam logic signed [8:0] CR_COEF_B = -9'sd18;
   localparam logic signed [8:0] CR_OFFSET = 9'sd128;

   // pink window on chroma, inclusive
   localparam logic [CHAN_W-1:0] MASK_LOWER = 8'hA0;
   localparam logic [CHAN_W-1:0] MASK_UPPER = 8'hF0;

   // pipeline depth of chroma_mask
   localparam int CHROMA_LATENCY = 3;

   typedef struct packed {
      logic [HCOUNT_W-1:0] x;
      logic [VCOUNT_W-1:0] y;
   } px_coord_t;

   typedef enum logic [1:0] {
      MODE_CAMERA    = 2'd0,
      MODE_LUMA      = 2'd1,
      MODE_MASK      = 2'd2,
      MODE_CROSSHAIR = 2'd3
   } display_mode_t;

endpackage
